// File: hdl/lcd_pkg.sv
// LCD timing core shared definitions
// Register offsets, counter widths, line and frame constants
// and the STAT mode encoding
package lcd_pkg;

    // Register offset within the I/O page
    typedef logic [7:0] reg_addr_t;
    // Line number, 0 to 153
    typedef logic [7:0] line_t;
    // 4-cycle ticks within a line, 0 to 113
    typedef logic [6:0] dot_t;
    // Pixel counter, 0 to 168
    typedef logic [7:0] pcnt_t;

    // STAT mode field encoding
    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_OAM    = 2'd2,
        MODE_XFER   = 2'd3
    } lcd_mode_t;

    // ------------------------------------------------------------
    // Register offsets
    localparam reg_addr_t ADDR_LCDC = 8'h40;
    localparam reg_addr_t ADDR_STAT = 8'h41;
    localparam reg_addr_t ADDR_SCX  = 8'h43;
    localparam reg_addr_t ADDR_LYC  = 8'h45;

    // ------------------------------------------------------------
    // Line and frame geometry
    localparam dot_t       TICKS_PER_LINE     = 7'd114;
    localparam line_t      VISIBLE_LINES      = 8'd144;
    localparam line_t      LAST_LINE          = 8'd153;
    localparam pcnt_t      PCNT_FIRST_VISIBLE = 8'd8;
    localparam pcnt_t      PCNT_LAST          = 8'd168;
    localparam logic [2:0] FETCH_CYCLES       = 3'd6;
    localparam logic [3:0] SHIFT_DEPTH        = 4'd8;

    // Bit positions in STAT and LCDC
    localparam int unsigned STAT_LYC_IE = 6;
    localparam int unsigned STAT_OAM_IE = 5;
    localparam int unsigned STAT_VBL_IE = 4;
    localparam int unsigned STAT_HBL_IE = 3;
    localparam int unsigned LCDC_ON     = 7;

endpackage

// File: hdl/lcd_regs.sv
// LCD register block
// CPU write decode for LCDC, STAT, SCX and LYC
`timescale 1ns/10ps

module lcd_regs
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ce_cpu,
    input  logic       cpu_sel_reg,
    input  logic       cpu_wr,
    input  reg_addr_t  cpu_addr,
    input  logic [7:0] cpu_di,
    output logic       lcd_on,
    output logic [3:0] stat_ie,
    output logic [2:0] scx_fine,
    output line_t      lyc
);

    logic       wr_en;
    logic       lcdc_on_r;
    logic [3:0] stat_ie_r;
    logic [2:0] scx_fine_r;
    line_t      lyc_r;

    // Write strobe, lands on the same edge
    assign wr_en = ce_cpu & cpu_sel_reg & cpu_wr;

    // ------------------------------------------------------------
    // Register file
    // Only the bits this core consumes are stored
    always_ff @(posedge clk) begin
        if (reset) begin
            lcdc_on_r  <= 1'b0;
            stat_ie_r  <= 4'd0;
            scx_fine_r <= 3'd0;
            lyc_r      <= '0;
        end else if (wr_en) begin
            case (cpu_addr)
                ADDR_LCDC: lcdc_on_r  <= cpu_di[LCDC_ON];
                ADDR_STAT: stat_ie_r  <= cpu_di[STAT_LYC_IE:STAT_HBL_IE];
                // Coarse scroll only feeds the tile map address
                ADDR_SCX:  scx_fine_r <= cpu_di[2:0];
                ADDR_LYC:  lyc_r      <= cpu_di;
                default: ;
            endcase
        end
    end

    // Monochrome STAT quirk
    // All four enables read as set during the write cycle
    assign stat_ie = (wr_en && cpu_addr == ADDR_STAT) ? 4'hF : stat_ie_r;

    assign lcd_on   = lcdc_on_r;
    assign scx_fine = scx_fine_r;
    assign lyc      = lyc_r;

endmodule

// File: hdl/lcd_timing.sv
// LCD line and frame timing
// Dot divider, tick and line counters, end-of-line pulse,
// vblank flags, vsync and the restart after LCD enable
`timescale 1ns/10ps

module lcd_timing
    import lcd_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  ce,
    input  logic  lcd_on,
    output logic  restart,
    output logic  h_clk_en,
    output logic  h_clk_en_neg,
    output logic  end_of_line,
    output logic  vblank_now,
    output logic  vblank_t,
    output line_t ly,
    output logic  lcd_vsync
);

    logic       lcd_on_d;
    logic [1:0] h_div_cnt;
    dot_t       h_cnt;
    logic       hcnt_end;
    logic       line_last;
    logic       vcnt_reset;
    logic       vcnt_eol_l;

    // ------------------------------------------------------------
    // Restart, held while off and one ce cycle after switch-on
    always_ff @(posedge clk) begin
        if (reset)
            lcd_on_d <= 1'b0;
        else if (ce)
            lcd_on_d <= lcd_on;
    end

    assign restart = ~(lcd_on & lcd_on_d);

    // Divide by 4, tick strobes on phases 0 and 2
    assign h_clk_en     = ~restart & (h_div_cnt == 2'd0);
    assign h_clk_en_neg = ~restart & (h_div_cnt == 2'd2);
    assign hcnt_end     = (h_cnt == TICKS_PER_LINE - 7'd1);
    assign vblank_now   = (ly >= VISIBLE_LINES);
    assign line_last    = (ly == LAST_LINE);

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            h_div_cnt <= 2'd0;
            h_cnt     <= '0;
        end else if (ce) begin
            h_div_cnt <= h_div_cnt + 2'd1;
            if (h_clk_en)
                h_cnt <= hcnt_end ? '0 : h_cnt + 7'd1;
        end
    end

    // ------------------------------------------------------------
    // End of line, 4 ce cycles from the last tick
    // vblank_t samples inside the pulse, so OAM irq of line 144 fires
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            end_of_line <= 1'b0;
            vblank_t    <= 1'b0;
        end else if (ce) begin
            if (h_clk_en_neg && hcnt_end) begin
                end_of_line <= 1'b1;
            end else if (end_of_line) begin
                if (h_clk_en)
                    vblank_t <= vblank_now;
                if (h_clk_en_neg)
                    end_of_line <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Line counter and vsync
    // Line 153 wraps to 0 early and is held for the next line
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            vcnt_eol_l <= 1'b0;
            vcnt_reset <= 1'b0;
            ly         <= '0;
            lcd_vsync  <= 1'b0;
        end else if (ce) begin
            if (!vcnt_reset && h_clk_en_neg && hcnt_end)
                ly <= ly + 8'd1;
            if (h_clk_en) begin
                vcnt_eol_l <= end_of_line;
                // Falling edge of the delayed pulse
                if (vcnt_eol_l && !end_of_line) begin
                    vcnt_reset <= line_last;
                    if (line_last)
                        ly <= '0;
                    // First frame after enable has no vsync, line 1 sees it first
                    lcd_vsync <= (ly == 8'd0);
                end
            end
        end
    end

endmodule

// File: hdl/pixel_fetch.sv
// Background fetch pacing and pixel clock enable
// Fetch warm-up, fine-scroll skip and 160 visible dots per line
`timescale 1ns/10ps

module pixel_fetch
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  logic       restart,
    input  logic       h_clk_en,
    input  logic       end_of_line,
    input  logic       vblank_now,
    input  logic [2:0] scx_fine,
    input  logic       mode3,
    output logic       pcnt_reset,
    output logic       mode3_end,
    output logic       lcd_clkena
);

    pcnt_t      pcnt;
    logic [2:0] skip_cnt;
    logic       skip_done;
    logic       skip_end;
    logic       skip_en;
    logic [2:0] fetch_cycle;
    logic [3:0] shift_cnt;
    logic       fetch_done;
    logic       shift_empty;
    logic       shift_reload;
    logic       pcnt_end;
    logic       lcd_clk;

    // ------------------------------------------------------------
    // Background fetch, 6 cycles then an 8 deep shift
    assign fetch_done   = (fetch_cycle >= FETCH_CYCLES - 3'd1);
    assign shift_empty  = (shift_cnt == 4'd0);
    assign shift_reload = (shift_cnt <= 4'd1);

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            fetch_cycle <= 3'd0;
            shift_cnt   <= 4'd0;
        end else if (ce) begin
            if (!mode3) begin
                // Idle outside transfer, next line starts with a warm-up
                fetch_cycle <= 3'd0;
                shift_cnt   <= 4'd0;
            end else begin
                if (fetch_cycle != 3'd7)
                    fetch_cycle <= fetch_cycle + 3'd1;
                if (!shift_empty)
                    shift_cnt <= shift_cnt - 4'd1;
                // Refill as the last pixel leaves, so the shift never runs dry
                if (fetch_done && shift_reload) begin
                    shift_cnt   <= SHIFT_DEPTH;
                    fetch_cycle <= 3'd0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Fine scroll skip and pixel counter
    assign pcnt_end   = (pcnt == PCNT_LAST);
    assign skip_end   = (skip_cnt == scx_fine);
    assign skip_en    = ~skip_done & ~skip_end;
    assign pcnt_reset = h_clk_en & end_of_line & ~vblank_now;

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            skip_cnt  <= 3'd0;
            skip_done <= 1'b0;
            pcnt      <= '0;
        end else if (ce) begin
            if (!shift_empty) begin
                if (!skip_done) begin
                    if (!skip_end)
                        skip_cnt <= skip_cnt + 3'd1;
                    else
                        skip_done <= 1'b1;
                end
                // Counts 0-7 are offscreen, 8-167 reach the display
                if (!skip_en && !pcnt_end)
                    pcnt <= pcnt + 8'd1;
            end
            if (pcnt_reset) begin
                skip_cnt  <= 3'd0;
                skip_done <= 1'b0;
                pcnt      <= '0;
            end
        end
    end

    assign lcd_clk   = mode3 & ~skip_en & ~shift_empty & (pcnt >= PCNT_FIRST_VISIBLE);
    assign mode3_end = (lcd_clk & (pcnt == PCNT_LAST - 8'd1)) | pcnt_end;

    // Pixel clock enable, one ce behind the internal clock
    always_ff @(posedge clk) begin
        if (reset || restart)
            lcd_clkena <= 1'b0;
        else if (ce)
            lcd_clkena <= lcd_clk;
    end

endmodule

// File: hdl/stat_irq.sv
// STAT conditions, mode output and LCD interrupt
// Latches LYC match, end of line, vblank and end of transfer
`timescale 1ns/10ps

module stat_irq
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  logic       restart,
    input  logic       lcd_on,
    input  logic       h_clk_en,
    input  logic       end_of_line,
    input  logic       vblank_t,
    input  logic       pcnt_reset,
    input  logic       mode3_end,
    input  line_t      ly,
    input  line_t      lyc,
    input  logic [3:0] stat_ie,
    output logic       mode3,
    output lcd_mode_t  mode,
    output logic       irq,
    output logic       vblank_irq
);

    logic lyc_match;
    logic lyc_match_t;
    logic lyc_match_l;
    logic end_of_line_l;
    logic vblank_l;
    logic mode3_end_l;
    logic oam_scan;
    logic oam_scan_l;
    logic mode3_l;
    logic mode_vblank;
    logic int_lyc;
    logic int_oam;
    logic int_vbl;
    logic int_hbl;

    // ------------------------------------------------------------
    // LYC compare, kept across LCD off
    assign lyc_match = (ly == lyc);

    always_ff @(posedge clk) begin
        if (reset) begin
            lyc_match_t <= 1'b0;
            lyc_match_l <= 1'b0;
        end else if (ce) begin
            lyc_match_l <= lyc_match_t;
            if (h_clk_en) begin
                lyc_match_t <= lyc_match;
                // Falling edge one tick early on the monochrome model
                if (lyc_match_t && !lyc_match)
                    lyc_match_l <= lyc_match;
            end
        end
    end

    // ------------------------------------------------------------
    // Line state latches and delayed mode levels
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            end_of_line_l <= 1'b0;
            vblank_l      <= 1'b0;
            mode3_end_l   <= 1'b0;
            mode3_l       <= 1'b0;
            oam_scan_l    <= 1'b0;
        end else if (ce) begin
            end_of_line_l <= end_of_line;
            vblank_l      <= vblank_t;
            mode3_end_l   <= pcnt_reset ? 1'b0 : mode3_end;
            mode3_l       <= mode3;
            oam_scan_l    <= oam_scan;
        end
    end

    // OAM scan window at the line boundary of a visible line
    assign oam_scan = lcd_on & end_of_line_l & ~vblank_t;
    // Transfer runs from the scan end until the last pixel
    assign mode3    = lcd_on & ~mode3_end_l & ~oam_scan;

    // Mode 0 shows for one cycle between vblank and mode 2
    assign mode_vblank = vblank_l & vblank_t;

    always_comb begin
        if (mode_vblank)
            mode = MODE_VBLANK;
        else if (oam_scan_l)
            mode = MODE_OAM;
        else if (mode3_l && !mode3_end)
            mode = MODE_XFER;
        else
            mode = MODE_HBLANK;
    end

    // ------------------------------------------------------------
    // Interrupt sources, ORed into one level
    assign int_lyc = stat_ie[STAT_LYC_IE - STAT_HBL_IE] & lyc_match_l;
    assign int_oam = stat_ie[STAT_OAM_IE - STAT_HBL_IE] & end_of_line_l & ~vblank_l;
    assign int_vbl = stat_ie[STAT_VBL_IE - STAT_HBL_IE] & vblank_l;
    assign int_hbl = stat_ie[0] & mode3_end_l & ~vblank_l;

    // LYC latch survives LCD off, so the line is masked here
    assign irq        = lcd_on & (int_lyc | int_oam | int_vbl | int_hbl);
    assign vblank_irq = vblank_l;

endmodule

// File: hdl/lcd_video_top.sv
// LCD timing core top level
// Registers, line timing, pixel pacing and STAT interrupt
`timescale 1ns/10ps

module lcd_video_top
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ce,
    input  logic       ce_cpu,
    input  logic       cpu_sel_reg,
    input  logic       cpu_wr,
    input  reg_addr_t  cpu_addr,
    input  logic [7:0] cpu_di,
    output logic       lcd_on,
    output logic       lcd_clkena,
    output logic       lcd_vsync,
    output lcd_mode_t  mode,
    output logic       irq,
    output logic       vblank_irq
);

    logic       restart;
    logic       h_clk_en;
    logic       end_of_line;
    logic       vblank_now;
    logic       vblank_t;
    line_t      ly;
    line_t      lyc;
    logic [3:0] stat_ie;
    logic [2:0] scx_fine;
    logic       pcnt_reset;
    logic       mode3_end;
    logic       mode3;

    // ------------------------------------------------------------
    lcd_regs regs_i (
        .clk         (clk),
        .reset       (reset),
        .ce_cpu      (ce_cpu),
        .cpu_sel_reg (cpu_sel_reg),
        .cpu_wr      (cpu_wr),
        .cpu_addr    (cpu_addr),
        .cpu_di      (cpu_di),
        .lcd_on      (lcd_on),
        .stat_ie     (stat_ie),
        .scx_fine    (scx_fine),
        .lyc         (lyc)
    );

    // Phase 2 strobe is only used inside the timing block
    lcd_timing timing_i (
        .clk          (clk),
        .reset        (reset),
        .ce           (ce),
        .lcd_on       (lcd_on),
        .restart      (restart),
        .h_clk_en     (h_clk_en),
        .h_clk_en_neg (),
        .end_of_line  (end_of_line),
        .vblank_now   (vblank_now),
        .vblank_t     (vblank_t),
        .ly           (ly),
        .lcd_vsync    (lcd_vsync)
    );

    pixel_fetch fetch_i (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .restart     (restart),
        .h_clk_en    (h_clk_en),
        .end_of_line (end_of_line),
        .vblank_now  (vblank_now),
        .scx_fine    (scx_fine),
        .mode3       (mode3),
        .pcnt_reset  (pcnt_reset),
        .mode3_end   (mode3_end),
        .lcd_clkena  (lcd_clkena)
    );

    stat_irq stat_i (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .restart     (restart),
        .lcd_on      (lcd_on),
        .h_clk_en    (h_clk_en),
        .end_of_line (end_of_line),
        .vblank_t    (vblank_t),
        .pcnt_reset  (pcnt_reset),
        .mode3_end   (mode3_end),
        .ly          (ly),
        .lyc         (lyc),
        .stat_ie     (stat_ie),
        .mode3       (mode3),
        .mode        (mode),
        .irq         (irq),
        .vblank_irq  (vblank_irq)
    );

endmodule

// File: bench/lcd_video_props.sv
// STAT block relation checks
// Bound into stat_irq, compares mode, vblank and irq levels
`timescale 1ns/10ps

module lcd_video_props
    import lcd_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      lcd_on,
    input logic      vblank_t,
    input lcd_mode_t mode,
    input logic      irq
);

    // Read by the testbench at the end of the run
    int fail_count;

    initial fail_count = 0;

    // ------------------------------------------------------------
    // No transfer inside vblank
    xfer_outside_vblank: assert property (
        @(posedge clk) disable iff (reset) vblank_t |-> (mode != MODE_XFER)
    ) else begin
        $error("mode is MODE_XFER while vblank_t is high");
        fail_count++;
    end

    // LCD off silences the interrupt
    irq_off_when_lcd_off: assert property (
        @(posedge clk) disable iff (reset) !lcd_on |-> !irq
    ) else begin
        $error("irq is high while the LCD is off");
        fail_count++;
    end

endmodule

bind stat_irq lcd_video_props props_i (
    .clk      (clk),
    .reset    (reset),
    .lcd_on   (lcd_on),
    .vblank_t (vblank_t),
    .mode     (mode),
    .irq      (irq)
);

// File: bench/lcd_video_tb.sv
// LCD timing core testbench
// Register writes, per-frame event counts between vsync edges,
// compared with a reference model of the frame timing
`timescale 1ns/10ps

module lcd_video_tb
    import lcd_pkg::*;
();

    // Frame geometry of the console
    localparam int DOTS_PER_LINE   = 456;
    localparam int LINES_PER_FRAME = 154;
    localparam int VISIBLE_ROWS    = 144;
    localparam int VISIBLE_DOTS    = 160;
    localparam int FRAME_CYCLES    = DOTS_PER_LINE * LINES_PER_FRAME;
    // Kinds of per-frame counts
    localparam int CNT_CYCLES   = 0;
    localparam int CNT_CLKENA   = 1;
    localparam int CNT_IRQ      = 2;
    localparam int CNT_VBL_IRQ  = 3;
    localparam int CNT_VBL_MODE = 4;

    logic       clk;
    logic       reset;
    logic       ce;
    logic       ce_cpu;
    logic       cpu_sel_reg;
    logic       cpu_wr;
    reg_addr_t  cpu_addr;
    logic [7:0] cpu_di;
    logic       lcd_on;
    logic       lcd_clkena;
    logic       lcd_vsync;
    lcd_mode_t  mode;
    logic       irq;
    logic       vblank_irq;

    int          errors;
    bit          timed_out;
    bit          measure;
    bit          frame_started;
    int          rise_count;
    int          frames_checked;
    int          frames_wanted;
    logic [3:0]  cur_ie;
    logic [31:0] rng;
    // Per-frame counters
    int          cyc_cnt;
    int          clkena_cnt;
    int          irq_cnt;
    int          vbl_irq_cnt;
    int          vbl_mode_cnt;
    logic [3:0]  seen;
    logic        vsync_prev;
    logic        irq_prev;
    logic        vbl_irq_prev;
    lcd_mode_t   mode_prev;

    lcd_video_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .ce_cpu      (ce_cpu),
        .cpu_sel_reg (cpu_sel_reg),
        .cpu_wr      (cpu_wr),
        .cpu_addr    (cpu_addr),
        .cpu_di      (cpu_di),
        .lcd_on      (lcd_on),
        .lcd_clkena  (lcd_clkena),
        .lcd_vsync   (lcd_vsync),
        .mode        (mode),
        .irq         (irq),
        .vblank_irq  (vblank_irq)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------
    // Reference model of one frame
    function automatic int expected_count(input int kind, input logic [3:0] ie);
        int n;
        case (kind)
            CNT_CYCLES: n = FRAME_CYCLES;
            CNT_CLKENA: n = VISIBLE_ROWS * VISIBLE_DOTS;
            // One LYC line and one vblank period per frame, as separate edges
            CNT_IRQ:    n = int'(ie[3]) + int'(ie[1]);
            default:    n = 1;
        endcase
        return n;
    endfunction

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        cpu_sel_reg <= 1'b1;
        cpu_wr      <= 1'b1;
        cpu_addr    <= addr;
        cpu_di      <= data;
        @(posedge clk);
        cpu_sel_reg <= 1'b0;
        cpu_wr      <= 1'b0;
    endtask

    // First rise after enable comes a little over one frame late
    task automatic wait_rises(input int n);
        int start;
        int t;
        start = rise_count;
        t = 0;
        while (!timed_out && rise_count < start + n && t < (n + 2) * FRAME_CYCLES) begin
            @(posedge clk);
            t++;
        end
        if (!timed_out && rise_count < start + n) begin
            $display("Timeout: lcd_vsync rose %0d of %0d times", rise_count - start, n);
            timed_out = 1'b1;
        end
    endtask

    // Enable, check n full frames, switch off again
    task automatic measure_frames(input int n);
        measure = 1'b1;
        frames_wanted += n;
        write_reg(ADDR_LCDC, 8'h80);
        @(negedge clk);
        check_count("lcd_on", int'(lcd_on), 1);
        wait_rises(n + 1);
        measure = 1'b0;
        write_reg(ADDR_LCDC, 8'h00);
    endtask

    // Everything silent for one frame length with the LCD off
    task automatic quiet_check();
        int n;
        int start_err;
        start_err = errors;
        repeat (2) @(posedge clk);
        for (n = 0; n < FRAME_CYCLES && errors == start_err; n++) begin
            @(negedge clk);
            check_count("lcd_clkena", int'(lcd_clkena), 0);
            check_count("lcd_vsync", int'(lcd_vsync), 0);
            check_count("irq", int'(irq), 0);
            check_count("mode", int'(mode), int'(MODE_HBLANK));
        end
    endtask

    // ------------------------------------------------------------
    // Comparison process, one frame between vsync rising edges
    always @(negedge clk) begin
        if (reset || !measure) begin
            frame_started = 1'b0;
        end else begin
            if (lcd_vsync && !vsync_prev) begin
                rise_count++;
                // First edge after enable only opens a frame
                if (frame_started) begin
                    frames_checked++;
                    check_count("lcd_vsync period", cyc_cnt, expected_count(CNT_CYCLES, cur_ie));
                    check_count("lcd_clkena count", clkena_cnt,
                                expected_count(CNT_CLKENA, cur_ie));
                    check_count("irq rises", irq_cnt, expected_count(CNT_IRQ, cur_ie));
                    check_count("vblank_irq rises", vbl_irq_cnt,
                                expected_count(CNT_VBL_IRQ, cur_ie));
                    check_count("mode vblank entries", vbl_mode_cnt,
                                expected_count(CNT_VBL_MODE, cur_ie));
                    check_count("mode values seen", int'(seen), 15);
                end
                frame_started = 1'b1;
                cyc_cnt = 0;
                clkena_cnt = 0;
                irq_cnt = 0;
                vbl_irq_cnt = 0;
                vbl_mode_cnt = 0;
                seen = 4'h0;
            end
            cyc_cnt++;
            if (lcd_clkena)
                clkena_cnt++;
            if (irq && !irq_prev)
                irq_cnt++;
            if (vblank_irq && !vbl_irq_prev)
                vbl_irq_cnt++;
            if (mode == MODE_VBLANK && mode_prev != MODE_VBLANK)
                vbl_mode_cnt++;
            seen[mode] = 1'b1;
        end
        vsync_prev = lcd_vsync;
        irq_prev = irq;
        vbl_irq_prev = vblank_irq;
        mode_prev = mode;
    end

    // ------------------------------------------------------------
    initial begin : main_seq
        int i;
        logic [7:0] lyc_val;
        clk = 1'b0;
        reset = 1'b1;
        ce = 1'b1;
        ce_cpu = 1'b1;
        cpu_sel_reg = 1'b0;
        cpu_wr = 1'b0;
        cpu_addr = '0;
        cpu_di = 8'h00;
        errors = 0;
        timed_out = 1'b0;
        measure = 1'b0;
        rise_count = 0;
        frames_checked = 0;
        frames_wanted = 0;
        cur_ie = 4'h0;
        rng = 32'd66;
        vsync_prev = 1'b0;
        irq_prev = 1'b0;
        vbl_irq_prev = 1'b0;
        mode_prev = MODE_HBLANK;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_count("lcd_on", int'(lcd_on), 0);
        check_count("lcd_clkena", int'(lcd_clkena), 0);
        check_count("lcd_vsync", int'(lcd_vsync), 0);
        check_count("irq", int'(irq), 0);
        check_count("vblank_irq", int'(vblank_irq), 0);
        check_count("mode", int'(mode), int'(MODE_HBLANK));

        // Frame period and pixel count for random fine scroll
        write_reg(ADDR_STAT, 8'h00);
        for (i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            write_reg(ADDR_SCX, rng[7:0]);
            measure_frames(2);
        end

        // LYC interrupt alone, line 1 to 143
        rng = xorshift32(rng);
        lyc_val = 8'(32'd1 + (rng % 32'd143));
        write_reg(ADDR_LYC, lyc_val);
        write_reg(ADDR_STAT, 8'h40);
        cur_ie = 4'b1000;
        measure_frames(2);

        // Vblank interrupt alone
        write_reg(ADDR_STAT, 8'h10);
        cur_ie = 4'b0010;
        measure_frames(2);

        // Both sources, then off for a frame and on again
        write_reg(ADDR_STAT, 8'h50);
        cur_ie = 4'b1010;
        measure_frames(1);
        quiet_check();
        measure_frames(2);

        check_count("frames checked", frames_checked, frames_wanted);
        $display("Frames %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 frames_checked, errors, dut_i.stat_i.props_i.fail_count, int'(timed_out));
        if (errors == 0 && !timed_out && dut_i.stat_i.props_i.fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
hdl/lcd_pkg.sv
hdl/lcd_regs.sv
hdl/lcd_timing.sv
hdl/pixel_fetch.sv
hdl/stat_irq.sv
hdl/lcd_video_top.sv
bench/lcd_video_props.sv
bench/lcd_video_tb.sv

// File: Makefile
# Verilator flow for the LCD timing core
SIM    = verilator
TOP    = lcd_video_tb
FLIST  = flist.f
FLAGS  = --binary --timing --assert -j 0
LINT   = --lint-only -Wall --timing
OUTDIR = obj_dir
LOG    = sim.log
PASS   = TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OUTDIR)

run: build
	./$(OUTDIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OUTDIR) $(LOG)
